//--- design/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// integer register and datapath width
`define RV_XLEN 64

// architectural integer registers
`define RV_REG_NUM 32

// bits needed to name one register
`define RV_REG_AW 5

`endif

//--- design/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   xword_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_REG,
        SRC1_PC,
        SRC1_ZERO
    } src1_sel_e;

    // four is the link offset for jal/jalr
    typedef enum logic [1:0] {
        SRC2_REG,
        SRC2_IMM,
        SRC2_FOUR
    } src2_sel_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_JAL,
        BR_JALR,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_type_e;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_B,
        MEM_H,
        MEM_W,
        MEM_D
    } mem_size_e;

endpackage

//--- design/id_ctrl.sv
`timescale 1ns/1ps

module id_ctrl
    import rv_pkg::*;
(
    input  logic [31:0] inst_i,
    output alu_op_e     alu_op_o,
    output src1_sel_e   src1_sel_o,
    output src2_sel_e   src2_sel_o,
    output imm_sel_e    imm_sel_o,
    output br_type_e    br_type_o,
    output logic        rd_we_o,
    output logic        mem_en_o,
    output logic        mem_we_o,
    output mem_size_e   mem_size_o,
    output logic        mem_unsigned_o,
    output logic        load_o,
    output logic        rs1_re_o,
    output logic        rs2_re_o
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       illegal;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // alt picks sub/sra over add/srl
    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        alu_op_o       = ALU_ADD;
        src1_sel_o     = SRC1_REG;
        src2_sel_o     = SRC2_REG;
        imm_sel_o      = IMM_I;
        br_type_o      = BR_NONE;
        rd_we_o        = 1'b0;
        mem_en_o       = 1'b0;
        mem_we_o       = 1'b0;
        mem_size_o     = mem_size_e'(funct3[1:0]);
        mem_unsigned_o = 1'b0;
        load_o         = 1'b0;
        rs1_re_o       = 1'b0;
        rs2_re_o       = 1'b0;
        illegal        = 1'b0;
        case (opcode)
            OPC_LUI: begin
                rd_we_o    = 1'b1;
                src1_sel_o = SRC1_ZERO;
                src2_sel_o = SRC2_IMM;
                imm_sel_o  = IMM_U;
                alu_op_o   = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                rd_we_o    = 1'b1;
                src1_sel_o = SRC1_PC;
                src2_sel_o = SRC2_IMM;
                imm_sel_o  = IMM_U;
            end
            OPC_JAL: begin
                rd_we_o    = 1'b1;
                src1_sel_o = SRC1_PC;
                src2_sel_o = SRC2_FOUR;
                imm_sel_o  = IMM_J;
                br_type_o  = BR_JAL;
            end
            OPC_JALR: begin
                rd_we_o    = 1'b1;
                rs1_re_o   = 1'b1;
                src1_sel_o = SRC1_PC;
                src2_sel_o = SRC2_FOUR;
                br_type_o  = BR_JALR;
                illegal    = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                rs1_re_o  = 1'b1;
                rs2_re_o  = 1'b1;
                imm_sel_o = IMM_B;
                alu_op_o  = ALU_SUB;
                case (funct3)
                    3'b000:  br_type_o = BR_EQ;
                    3'b001:  br_type_o = BR_NE;
                    3'b100:  br_type_o = BR_LT;
                    3'b101:  br_type_o = BR_GE;
                    3'b110:  br_type_o = BR_LTU;
                    3'b111:  br_type_o = BR_GEU;
                    default: illegal   = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                rd_we_o        = 1'b1;
                rs1_re_o       = 1'b1;
                mem_en_o       = 1'b1;
                load_o         = 1'b1;
                src2_sel_o     = SRC2_IMM;
                mem_unsigned_o = funct3[2];
                // no unsigned double
                illegal        = (funct3 == 3'b111);
            end
            OPC_STORE: begin
                rs1_re_o   = 1'b1;
                rs2_re_o   = 1'b1;
                mem_en_o   = 1'b1;
                mem_we_o   = 1'b1;
                src2_sel_o = SRC2_IMM;
                imm_sel_o  = IMM_S;
                illegal    = funct3[2];
            end
            OPC_OP_IMM: begin
                rd_we_o    = 1'b1;
                rs1_re_o   = 1'b1;
                src2_sel_o = SRC2_IMM;
                alu_op_o   = f3_to_alu(funct3, funct3 == 3'b101 && inst_i[30]);
                // rv64 shifts carry a 6-bit shamt
                if (funct3 == 3'b001) begin
                    illegal = (inst_i[31:26] != 6'b000000);
                end else if (funct3 == 3'b101) begin
                    illegal = (inst_i[31:26] != 6'b000000) && (inst_i[31:26] != 6'b010000);
                end
            end
            OPC_OP: begin
                rd_we_o  = 1'b1;
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
                alu_op_o = f3_to_alu(funct3, funct7[5]);
                if (funct7 == 7'b0100000) begin
                    illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                end else begin
                    illegal = (funct7 != 7'b0000000);
                end
            end
            default: illegal = 1'b1;
        endcase
        // unknown encodings become a no-op
        if (illegal) begin
            br_type_o = BR_NONE;
            rd_we_o   = 1'b0;
            mem_en_o  = 1'b0;
            mem_we_o  = 1'b0;
            load_o    = 1'b0;
            rs1_re_o  = 1'b0;
            rs2_re_o  = 1'b0;
        end
    end

endmodule

//--- design/id_regfile.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module id_regfile
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  xword_t    wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output xword_t    rdata1_o,
    output xword_t    rdata2_o
);

    xword_t regs [`RV_REG_NUM];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `RV_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is hardwired
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- design/id_bypass.sv
`timescale 1ns/1ps

module id_bypass
    import rv_pkg::*;
(
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  logic      rs1_re_i,
    input  logic      rs2_re_i,
    input  logic      ex_we_i,
    input  logic      ex_load_i,
    input  reg_addr_t ex_waddr_i,
    input  xword_t    ex_result_i,
    input  logic      mem_we_i,
    input  logic      mem_load_i,
    input  reg_addr_t mem_waddr_i,
    input  xword_t    mem_result_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_waddr_i,
    input  xword_t    wb_wdata_i,
    input  xword_t    rf_rdata1_i,
    input  xword_t    rf_rdata2_i,
    output xword_t    rs1_val_o,
    output xword_t    rs2_val_o,
    output logic      stall_o
);

    // youngest producer wins, loads excluded
    function automatic xword_t resolve(input reg_addr_t ra, input xword_t rf_val);
        xword_t val;
        if (ra == '0) begin
            val = rf_val;
        end else if (ex_we_i && !ex_load_i && ex_waddr_i == ra) begin
            val = ex_result_i;
        end else if (mem_we_i && !mem_load_i && mem_waddr_i == ra) begin
            val = mem_result_i;
        end else if (wb_we_i && wb_waddr_i == ra) begin
            val = wb_wdata_i;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    // load result not ready yet
    function automatic logic load_hazard(input reg_addr_t ra, input logic re);
        logic hit_ex;
        logic hit_mem;
        hit_ex  = ex_we_i && ex_load_i && ex_waddr_i == ra;
        hit_mem = mem_we_i && mem_load_i && mem_waddr_i == ra;
        return re && (ra != '0) && (hit_ex || hit_mem);
    endfunction

    always_comb begin
        rs1_val_o = resolve(rs1_i, rf_rdata1_i);
        rs2_val_o = resolve(rs2_i, rf_rdata2_i);
        stall_o   = load_hazard(rs1_i, rs1_re_i) || load_hazard(rs2_i, rs2_re_i);
    end

endmodule

//--- design/id_branch.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module id_branch
    import rv_pkg::*;
(
    input  xword_t   pc_i,
    input  xword_t   rs1_val_i,
    input  xword_t   rs2_val_i,
    input  xword_t   imm_b_i,
    input  xword_t   imm_i_i,
    input  xword_t   imm_j_i,
    input  br_type_e br_type_i,
    output logic     taken_o,
    output xword_t   target_o
);

    localparam int MSB = `RV_XLEN - 1;

    xword_t diff;
    logic   carry;
    logic   eq;
    logic   lt;
    logic   ltu;
    xword_t target_raw;

    // a - b as a + ~b + 1, carry out means a >= b unsigned
    assign {carry, diff} = {1'b0, rs1_val_i} + {1'b0, ~rs2_val_i} + 1'b1;

    assign eq  = (diff == '0);
    assign ltu = ~carry;
    assign lt  = (rs1_val_i[MSB] != rs2_val_i[MSB]) ? rs1_val_i[MSB] : diff[MSB];

    always_comb begin
        case (br_type_i)
            BR_JAL:  taken_o = 1'b1;
            BR_JALR: taken_o = 1'b1;
            BR_EQ:   taken_o = eq;
            BR_NE:   taken_o = ~eq;
            BR_LT:   taken_o = lt;
            BR_GE:   taken_o = ~lt;
            BR_LTU:  taken_o = ltu;
            BR_GEU:  taken_o = ~ltu;
            default: taken_o = 1'b0;
        endcase
    end

    always_comb begin
        case (br_type_i)
            BR_JAL:  target_raw = pc_i + imm_j_i;
            BR_JALR: target_raw = (rs1_val_i + imm_i_i) & {{MSB{1'b1}}, 1'b0};
            default: target_raw = pc_i + imm_b_i;
        endcase
    end

    assign target_o = taken_o ? target_raw : '0;

endmodule

//--- design/id_stage.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module id_stage
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    input  xword_t      pc_i,
    input  logic [31:0] inst_i,
    input  logic        wb_we_i,
    input  reg_addr_t   wb_waddr_i,
    input  xword_t      wb_wdata_i,
    input  logic        ex_we_i,
    input  logic        ex_load_i,
    input  reg_addr_t   ex_waddr_i,
    input  xword_t      ex_result_i,
    input  logic        mem_we_i,
    input  logic        mem_load_i,
    input  reg_addr_t   mem_waddr_i,
    input  xword_t      mem_result_i,
    output alu_op_e     alu_op_o,
    output xword_t      alu_src1_o,
    output xword_t      alu_src2_o,
    output xword_t      store_data_o,
    output logic        rd_we_o,
    output reg_addr_t   rd_addr_o,
    output logic        mem_en_o,
    output logic        mem_we_o,
    output mem_size_e   mem_size_o,
    output logic        mem_unsigned_o,
    output logic        load_o,
    output logic        branch_taken_o,
    output xword_t      branch_target_o,
    output logic        stall_o,
    output logic        sys_o
);

    localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
    localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

    reg_addr_t rs1;
    reg_addr_t rs2;
    xword_t    imm_i;
    xword_t    imm_s;
    xword_t    imm_b;
    xword_t    imm_u;
    xword_t    imm_j;
    xword_t    imm;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    imm_sel_e  imm_sel;
    br_type_e  br_type;
    logic      rs1_re;
    logic      rs2_re;
    xword_t    rf_rdata1;
    xword_t    rf_rdata2;
    xword_t    rs1_val;
    xword_t    rs2_val;

    assign rs1       = inst_i[19:15];
    assign rs2       = inst_i[24:20];
    assign rd_addr_o = inst_i[11:7];

    assign imm_i = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{(`RV_XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                    inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {{(`RV_XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                    inst_i[20], inst_i[30:21], 1'b0};

    id_ctrl u_ctrl (
        .inst_i         (inst_i),
        .alu_op_o       (alu_op_o),
        .src1_sel_o     (src1_sel),
        .src2_sel_o     (src2_sel),
        .imm_sel_o      (imm_sel),
        .br_type_o      (br_type),
        .rd_we_o        (rd_we_o),
        .mem_en_o       (mem_en_o),
        .mem_we_o       (mem_we_o),
        .mem_size_o     (mem_size_o),
        .mem_unsigned_o (mem_unsigned_o),
        .load_o         (load_o),
        .rs1_re_o       (rs1_re),
        .rs2_re_o       (rs2_re)
    );

    id_regfile u_regfile (
        .clk      (clk),
        .rst_i    (rst_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_waddr_i),
        .wdata_i  (wb_wdata_i),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    id_bypass u_bypass (
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .rs1_re_i     (rs1_re),
        .rs2_re_i     (rs2_re),
        .ex_we_i      (ex_we_i),
        .ex_load_i    (ex_load_i),
        .ex_waddr_i   (ex_waddr_i),
        .ex_result_i  (ex_result_i),
        .mem_we_i     (mem_we_i),
        .mem_load_i   (mem_load_i),
        .mem_waddr_i  (mem_waddr_i),
        .mem_result_i (mem_result_i),
        .wb_we_i      (wb_we_i),
        .wb_waddr_i   (wb_waddr_i),
        .wb_wdata_i   (wb_wdata_i),
        .rf_rdata1_i  (rf_rdata1),
        .rf_rdata2_i  (rf_rdata2),
        .rs1_val_o    (rs1_val),
        .rs2_val_o    (rs2_val),
        .stall_o      (stall_o)
    );

    id_branch u_branch (
        .pc_i      (pc_i),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val),
        .imm_b_i   (imm_b),
        .imm_i_i   (imm_i),
        .imm_j_i   (imm_j),
        .br_type_i (br_type),
        .taken_o   (branch_taken_o),
        .target_o  (branch_target_o)
    );

    always_comb begin
        case (imm_sel)
            IMM_S:   imm = imm_s;
            IMM_B:   imm = imm_b;
            IMM_U:   imm = imm_u;
            IMM_J:   imm = imm_j;
            default: imm = imm_i;
        endcase
    end

    always_comb begin
        case (src1_sel)
            SRC1_PC:   alu_src1_o = pc_i;
            SRC1_ZERO: alu_src1_o = '0;
            default:   alu_src1_o = rs1_val;
        endcase
    end

    // link value is pc + 4
    always_comb begin
        case (src2_sel)
            SRC2_IMM:  alu_src2_o = imm;
            SRC2_FOUR: alu_src2_o = xword_t'(4);
            default:   alu_src2_o = rs2_val;
        endcase
    end

    assign store_data_o = rs2_val;
    assign sys_o        = (inst_i == INST_ECALL) || (inst_i == INST_EBREAK);

endmodule

//--- tests/tb_id_stage.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_id_stage
    import rv_pkg::*;
();

    logic        clk;
    logic        rst_i;
    xword_t      pc_i;
    logic [31:0] inst_i;
    logic        wb_we_i;
    reg_addr_t   wb_waddr_i;
    xword_t      wb_wdata_i;
    logic        ex_we_i;
    logic        ex_load_i;
    reg_addr_t   ex_waddr_i;
    xword_t      ex_result_i;
    logic        mem_we_i;
    logic        mem_load_i;
    reg_addr_t   mem_waddr_i;
    xword_t      mem_result_i;
    alu_op_e     alu_op_o;
    xword_t      alu_src1_o;
    xword_t      alu_src2_o;
    xword_t      store_data_o;
    logic        rd_we_o;
    reg_addr_t   rd_addr_o;
    logic        mem_en_o;
    logic        mem_we_o;
    mem_size_e   mem_size_o;
    logic        mem_unsigned_o;
    logic        load_o;
    logic        branch_taken_o;
    xword_t      branch_target_o;
    logic        stall_o;
    logic        sys_o;

    // architectural register contents as the testbench expects them
    xword_t shadow [`RV_REG_NUM];

    id_stage dut_i (.*);

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s at %0t", why, $time);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input xword_t got, input xword_t exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run("value check failed");
        end
    endtask

    // outputs are combinational, so they settle before the falling edge
    task automatic settle();
        int waited;
        waited = 0;
        @(negedge clk);
        while ($isunknown({alu_src1_o, alu_src2_o, stall_o, branch_target_o}) && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if ($isunknown({alu_src1_o, alu_src2_o, stall_o, branch_target_o})) begin
            stop_run("outputs stayed unknown after the instruction was applied");
        end
    endtask

    function automatic xword_t rand_word();
        return {$urandom, $urandom};
    endfunction

    function automatic xword_t sext(input xword_t v, input int bits);
        xword_t m;
        m = xword_t'(1) << (bits - 1);
        return (v ^ m) - m;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3,
                                          input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input reg_addr_t rs1,
                                          input logic [2:0] f3, input reg_addr_t rd,
                                          input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // expected operands and memory fields for the non-branch forms
    task automatic ref_decode(input logic [31:0] inst, input xword_t pc,
                              output xword_t src1, output xword_t src2,
                              output logic rd_we, output logic mem_en,
                              output logic mem_we, output logic uns,
                              output logic [1:0] size, output alu_op_e op);
        xword_t imm_i;
        xword_t imm_s;
        xword_t imm_u;
        imm_i  = sext(xword_t'(inst[31:20]), 12);
        imm_s  = sext(xword_t'({inst[31:25], inst[11:7]}), 12);
        imm_u  = sext(xword_t'({inst[31:12], 12'h000}), 32);
        src1   = shadow[inst[19:15]];
        src2   = shadow[inst[24:20]];
        rd_we  = 1'b1;
        mem_en = 1'b0;
        mem_we = 1'b0;
        uns    = 1'b0;
        size   = inst[13:12];
        // add, addi, auipc and address generation all add
        op     = ALU_ADD;
        case (inst[6:0])
            7'b0110111: begin
                src1 = '0;
                src2 = imm_u;
                op   = ALU_PASS_B;
            end
            7'b0010111: begin
                src1 = pc;
                src2 = imm_u;
            end
            7'b0000011: begin
                src2   = imm_i;
                mem_en = 1'b1;
                uns    = inst[14];
            end
            7'b0100011: begin
                src2   = imm_s;
                mem_en = 1'b1;
                mem_we = 1'b1;
                rd_we  = 1'b0;
            end
            7'b0010011: src2 = imm_i;
            default: ;
        endcase
    endtask

    task automatic apply_inst(input logic [31:0] inst, input xword_t pc);
        @(posedge clk);
        inst_i <= inst;
        pc_i   <= pc;
        settle();
    endtask

    task automatic check_decode(input logic [31:0] inst, input xword_t pc);
        xword_t     src1;
        xword_t     src2;
        logic       rd_we;
        logic       mem_en;
        logic       mem_we;
        logic       uns;
        logic [1:0] size;
        alu_op_e    op;
        apply_inst(inst, pc);
        ref_decode(inst, pc, src1, src2, rd_we, mem_en, mem_we, uns, size, op);
        check_val("alu_src1_o", alu_src1_o, src1);
        check_val("alu_src2_o", alu_src2_o, src2);
        check_val("alu_op_o", xword_t'(alu_op_o), xword_t'(op));
        check_val("rd_we_o", xword_t'(rd_we_o), xword_t'(rd_we));
        check_val("mem_en_o", xword_t'(mem_en_o), xword_t'(mem_en));
        check_val("mem_we_o", xword_t'(mem_we_o), xword_t'(mem_we));
        check_val("load_o", xword_t'(load_o), xword_t'(mem_en && !mem_we));
        check_val("sys_o", xword_t'(sys_o), '0);
        if (rd_we) begin
            check_val("rd_addr_o", xword_t'(rd_addr_o), xword_t'(inst[11:7]));
        end
        if (mem_en) begin
            check_val("mem_size_o", xword_t'(mem_size_o), xword_t'(size));
            check_val("mem_unsigned_o", xword_t'(mem_unsigned_o), xword_t'(uns));
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input xword_t val);
        @(posedge clk);
        wb_we_i    <= 1'b1;
        wb_waddr_i <= addr;
        wb_wdata_i <= val;
        @(posedge clk);
        wb_we_i <= 1'b0;
        if (addr != '0) begin
            shadow[addr] = val;
        end
    endtask

    task automatic clear_producers();
        @(posedge clk);
        ex_we_i    <= 1'b0;
        ex_load_i  <= 1'b0;
        mem_we_i   <= 1'b0;
        mem_load_i <= 1'b0;
        wb_we_i    <= 1'b0;
    endtask

    task automatic reset_and_regfile();
        reg_addr_t a;
        reg_addr_t b;
        check_decode(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd3), '0);
        apply_inst(32'h0, '0);
        check_val("stall_o", xword_t'(stall_o), '0);
        check_val("mem_en_o", xword_t'(mem_en_o), '0);
        check_val("mem_we_o", xword_t'(mem_we_o), '0);
        check_val("rd_we_o", xword_t'(rd_we_o), '0);
        check_val("branch_taken_o", xword_t'(branch_taken_o), '0);
        // x0 is written too and must still read zero
        for (int r = 0; r < `RV_REG_NUM; r++) begin
            write_reg(reg_addr_t'(r), rand_word());
        end
        for (int n = 0; n < 16; n++) begin
            a = reg_addr_t'($urandom_range(31, 0));
            b = reg_addr_t'($urandom_range(31, 0));
            check_decode(enc_r(7'd0, b, a, 3'd0, 5'd3), '0);
        end
        check_decode(enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd3), '0);
    endtask

    task automatic decode_forms();
        xword_t pc;
        pc = rand_word() & ~xword_t'(3);
        write_reg(5'd7, rand_word());
        write_reg(5'd9, rand_word());
        write_reg(5'd10, rand_word());
        write_reg(5'd11, rand_word());
        check_decode(enc_i(-5, 5'd7, 3'b000, 5'd4, 7'b0010011), pc);
        check_decode(enc_i(1234, 5'd7, 3'b000, 5'd4, 7'b0010011), pc);
        // upper bit set, so lui sign-extends
        check_decode(enc_u(20'h80001, 5'd6, 7'b0110111), pc);
        check_decode(enc_u(20'h12345, 5'd6, 7'b0010111), pc);
        check_decode(enc_u(20'hfedcb, 5'd6, 7'b0010111), pc);
        check_decode(enc_i(-16, 5'd9, 3'b011, 5'd8, 7'b0000011), pc);
        check_decode(enc_i(7, 5'd9, 3'b100, 5'd8, 7'b0000011), pc);
        check_decode(enc_s(-2040, 5'd10, 5'd11, 3'b011), pc);
        apply_inst(32'h0000_0073, pc);
        check_val("sys_o", xword_t'(sys_o), xword_t'(1));
        check_val("rd_we_o", xword_t'(rd_we_o), '0);
        check_val("mem_en_o", xword_t'(mem_en_o), '0);
    endtask

    task automatic forwarding_priority();
        reg_addr_t r;
        xword_t    v_ex;
        xword_t    v_mem;
        xword_t    v_wb;
        xword_t    v_old;
        r     = reg_addr_t'($urandom_range(31, 1));
        v_ex  = rand_word();
        v_mem = rand_word();
        v_wb  = rand_word();
        v_old = rand_word();
        @(posedge clk);
        ex_we_i      <= 1'b1;
        ex_waddr_i   <= r;
        ex_result_i  <= v_ex;
        mem_we_i     <= 1'b1;
        mem_waddr_i  <= r;
        mem_result_i <= v_mem;
        wb_we_i      <= 1'b1;
        wb_waddr_i   <= r;
        wb_wdata_i   <= v_old;
        inst_i       <= enc_r(7'd0, r, r, 3'd0, 5'd2);
        settle();
        check_val("alu_src1_o", alu_src1_o, v_ex);
        check_val("store_data_o", store_data_o, v_ex);
        @(posedge clk);
        ex_we_i <= 1'b0;
        settle();
        check_val("alu_src1_o", alu_src1_o, v_mem);
        check_val("store_data_o", store_data_o, v_mem);
        // the file still holds the older wb data
        @(posedge clk);
        mem_we_i   <= 1'b0;
        wb_wdata_i <= v_wb;
        settle();
        check_val("alu_src1_o", alu_src1_o, v_wb);
        check_val("store_data_o", store_data_o, v_wb);
        @(posedge clk);
        wb_we_i <= 1'b0;
        settle();
        // wb held its write, so the file has it now
        shadow[r] = v_wb;
        check_val("alu_src1_o", alu_src1_o, shadow[r]);
        @(posedge clk);
        ex_we_i     <= 1'b1;
        ex_waddr_i  <= '0;
        mem_we_i    <= 1'b1;
        mem_waddr_i <= '0;
        wb_we_i     <= 1'b1;
        wb_waddr_i  <= '0;
        inst_i      <= enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd2);
        settle();
        check_val("alu_src1_o", alu_src1_o, '0);
        check_val("alu_src2_o", alu_src2_o, '0);
        clear_producers();
    endtask

    task automatic load_use_stall();
        reg_addr_t r;
        r = reg_addr_t'($urandom_range(31, 1));
        @(posedge clk);
        ex_we_i     <= 1'b1;
        ex_load_i   <= 1'b1;
        ex_waddr_i  <= r;
        ex_result_i <= rand_word();
        inst_i      <= enc_r(7'd0, 5'd0, r, 3'd0, 5'd3);
        settle();
        check_val("stall_o", xword_t'(stall_o), xword_t'(1));
        // load data is never forwarded
        check_val("alu_src1_o", alu_src1_o, shadow[r]);
        apply_inst(enc_r(7'd0, r, 5'd0, 3'd0, 5'd3), '0);
        check_val("stall_o", xword_t'(stall_o), xword_t'(1));
        // lui with rs1 field equal to r reads nothing
        apply_inst(enc_u({12'h000, r, 3'b000}, 5'd3, 7'b0110111), '0);
        check_val("stall_o", xword_t'(stall_o), '0);
        @(posedge clk);
        ex_we_i     <= 1'b0;
        ex_load_i   <= 1'b0;
        mem_we_i    <= 1'b1;
        mem_load_i  <= 1'b1;
        mem_waddr_i <= r;
        inst_i      <= enc_r(7'd0, 5'd0, r, 3'd0, 5'd3);
        settle();
        check_val("stall_o", xword_t'(stall_o), xword_t'(1));
        @(posedge clk);
        mem_waddr_i <= '0;
        inst_i      <= enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd3);
        settle();
        check_val("stall_o", xword_t'(stall_o), '0);
        clear_producers();
    endtask

    task automatic branches_and_jumps();
        logic [2:0] conds [6];
        xword_t     a;
        xword_t     b;
        xword_t     pc;
        xword_t     target;
        int         off;
        logic       taken;
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        // random, equal, and both sign-differing pairs
        for (int k = 0; k < 4; k++) begin
            a = rand_word();
            b = rand_word();
            if (k == 1) begin
                b = a;
            end
            if (k >= 2) begin
                a[`RV_XLEN-1] = (k == 2);
                b[`RV_XLEN-1] = (k == 3);
            end
            write_reg(5'd5, a);
            write_reg(5'd6, b);
            for (int c = 0; c < 6; c++) begin
                pc  = rand_word() & ~xword_t'(3);
                off = (int'($urandom_range(4095, 0)) - 2048) * 2;
                case (conds[c])
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                target = taken ? pc + xword_t'(longint'(off)) : '0;
                apply_inst(enc_b(off, 5'd6, 5'd5, conds[c]), pc);
                check_val("branch_taken_o", xword_t'(branch_taken_o), xword_t'(taken));
                check_val("branch_target_o", branch_target_o, target);
            end
        end
        pc  = rand_word() & ~xword_t'(3);
        off = (int'($urandom_range(1048575, 0)) - 524288) * 2;
        apply_inst(enc_j(off, 5'd1), pc);
        check_val("branch_taken_o", xword_t'(branch_taken_o), xword_t'(1));
        check_val("branch_target_o", branch_target_o, pc + xword_t'(longint'(off)));
        check_val("alu_src1_o", alu_src1_o, pc);
        check_val("alu_src2_o", alu_src2_o, xword_t'(4));
        check_val("alu_op_o", xword_t'(alu_op_o), xword_t'(ALU_ADD));
        check_val("rd_we_o", xword_t'(rd_we_o), xword_t'(1));
        check_val("rd_addr_o", xword_t'(rd_addr_o), xword_t'(1));
        // odd offset exercises the cleared bit 0
        off    = int'($urandom_range(4095, 0)) - 2048;
        off    = off | 1;
        target = (shadow[5] + xword_t'(longint'(off))) & ~xword_t'(1);
        apply_inst(enc_i(off, 5'd5, 3'b000, 5'd1, 7'b1100111), pc);
        check_val("branch_taken_o", xword_t'(branch_taken_o), xword_t'(1));
        check_val("branch_target_o", branch_target_o, target);
        check_val("alu_src1_o", alu_src1_o, pc);
        check_val("alu_src2_o", alu_src2_o, xword_t'(4));
        check_val("rd_we_o", xword_t'(rd_we_o), xword_t'(1));
        check_val("rd_addr_o", xword_t'(rd_addr_o), xword_t'(1));
    endtask

    initial begin
        #1_000_000;
        stop_run("simulation ran past its time limit");
    end

    initial begin
        void'($urandom(32'h2b19));
        rst_i        = 1'b1;
        pc_i         = '0;
        inst_i       = '0;
        wb_we_i      = 1'b0;
        wb_waddr_i   = '0;
        wb_wdata_i   = '0;
        ex_we_i      = 1'b0;
        ex_load_i    = 1'b0;
        ex_waddr_i   = '0;
        ex_result_i  = '0;
        mem_we_i     = 1'b0;
        mem_load_i   = 1'b0;
        mem_waddr_i  = '0;
        mem_result_i = '0;
        for (int i = 0; i < `RV_REG_NUM; i++) begin
            shadow[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        reset_and_regfile();
        decode_forms();
        forwarding_priority();
        load_use_stall();
        branches_and_jumps();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+design
design/rv_pkg.sv
design/id_ctrl.sv
design/id_regfile.sv
design/id_bypass.sv
design/id_branch.sv
design/id_stage.sv
tests/tb_id_stage.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_id_stage
FILELIST = sim.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with $(TOOL) and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
